/* include/dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// cpu address split, tag | index | byte offset
`define DCACHE_ADDR_W 32
`define DCACHE_TAG_W 20
`define DCACHE_INDEX_W 8
`define DCACHE_OFFSET_W 4

// data path
`define DCACHE_WORD_W 32
`define DCACHE_LINE_WORDS 4

`endif

/* source/cache_pkg.sv */
`default_nettype none

`include "dcache_settings.svh"

package cache_pkg;

    typedef logic [`DCACHE_WORD_W-1:0] word_t;
    typedef logic [`DCACHE_WORD_W/8-1:0] wsel_t;

    typedef logic [`DCACHE_TAG_W-1:0] tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0] index_t;
    typedef logic [`DCACHE_OFFSET_W-1:0] offset_t;

    typedef struct packed {
        tag_t tag;
        index_t index;
        offset_t offset;
    } addr_fields_t;

    // bus view and lookup view of one address
    typedef union packed {
        word_t raw;
        addr_fields_t fields;
    } addr_u;

    // word 0 sits in the low bits
    typedef word_t [`DCACHE_LINE_WORDS-1:0] line_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

    typedef struct packed {
        logic rvalid;
        logic wvalid;
        addr_u addr;
        wsel_t wsel;
        word_t wdata;
    } cpu_req_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        FILL
    } miss_state_e;

endpackage

`default_nettype wire

/* source/mem_pkg.sv */
`default_nettype none

`include "dcache_settings.svh"

package mem_pkg;

    // held until rd_valid or wr_done
    typedef struct packed {
        logic rd_req;
        logic wr_req;
        cache_pkg::addr_u addr;
        cache_pkg::line_t wdata;
    } mem_req_t;

    // single cycle pulses
    typedef struct packed {
        logic rd_valid;
        logic wr_done;
        cache_pkg::line_t rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* source/dcache_request_stage.sv */
`default_nettype none

module dcache_request_stage (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::cpu_req_t cpu_req_i,
    input  logic                stall_i,
    output cache_pkg::cpu_req_t stage_req_o,
    output cache_pkg::index_t   read_index_o
);

    cache_pkg::cpu_req_t stage_q;

    //////////////////////////////////////////////////
    // stage 2 request register
    //////////////////////////////////////////////////

    // request flags
    always_ff @(posedge clk) begin
        if (!rst) begin
            stage_q.rvalid <= 1'b0;
            stage_q.wvalid <= 1'b0;
        end else if (!stall_i) begin
            stage_q.rvalid <= cpu_req_i.rvalid;
            stage_q.wvalid <= cpu_req_i.wvalid;
        end
    end

    // address and write payload
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            stage_q.addr  <= cpu_req_i.addr;
            stage_q.wsel  <= cpu_req_i.wsel;
            stage_q.wdata <= cpu_req_i.wdata;
        end
    end

    assign stage_req_o = stage_q;

    //////////////////////////////////////////////////
    // array read index
    //////////////////////////////////////////////////

    // keep the held line on the array outputs while stalled
    assign read_index_o = stall_i ? stage_q.addr.fields.index
                                  : cpu_req_i.addr.fields.index;

endmodule

`default_nettype wire

/* source/dcache_way_store.sv */
`default_nettype none

`include "dcache_settings.svh"

module dcache_way_store (
    input  logic                                      clk,
    input  logic                                      rst,
    input  cache_pkg::index_t                         read_index_i,
    input  logic                                      write_en_i,
    input  cache_pkg::index_t                         write_index_i,
    input  cache_pkg::wsel_t [`DCACHE_LINE_WORDS-1:0] write_wsel_i,
    input  cache_pkg::tagv_t                          write_tagv_i,
    input  cache_pkg::line_t                          write_line_i,
    output cache_pkg::tagv_t                          tagv_o,
    output cache_pkg::line_t                          line_o
);

    localparam int SETS = 1 << `DCACHE_INDEX_W;
    localparam int BYTES = `DCACHE_WORD_W / 8;

    logic [SETS-1:0] valid_bits;
    cache_pkg::tag_t tag_mem [SETS];
    cache_pkg::line_t line_mem [SETS];

    cache_pkg::tagv_t rd_tagv;
    cache_pkg::line_t rd_line;
    cache_pkg::tagv_t tagv_q;
    cache_pkg::line_t line_q;
    logic collide;

    // valid bits, cleared on reset
    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_bits <= '0;
        end else if (write_en_i) begin
            valid_bits[write_index_i] <= write_tagv_i.valid;
        end
    end

    // tag and byte-lane line writes
    always_ff @(posedge clk) begin
        if (write_en_i) begin
            tag_mem[write_index_i] <= write_tagv_i.tag;
            for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
                for (int b = 0; b < BYTES; b++) begin
                    if (write_wsel_i[w][b]) begin
                        line_mem[write_index_i][w][8*b +: 8] <= write_line_i[w][8*b +: 8];
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // read port, write-first on the same index
    //////////////////////////////////////////////////

    assign collide = write_en_i && (write_index_i == read_index_i);

    always_comb begin
        rd_tagv.valid = valid_bits[read_index_i];
        rd_tagv.tag = tag_mem[read_index_i];
        rd_line = line_mem[read_index_i];
        if (collide) begin
            rd_tagv = write_tagv_i;
            for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
                for (int b = 0; b < BYTES; b++) begin
                    if (write_wsel_i[w][b]) begin
                        rd_line[w][8*b +: 8] = write_line_i[w][8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        tagv_q <= rd_tagv;
        line_q <= rd_line;
    end

    assign tagv_o = tagv_q;
    assign line_o = line_q;

endmodule

`default_nettype wire

/* source/dcache_controller.sv */
`default_nettype none

`include "dcache_settings.svh"

module dcache_controller (
    input  logic                                      clk,
    input  logic                                      rst,
    input  cache_pkg::cpu_req_t                       stage_req_i,
    input  cache_pkg::tagv_t                          way0_tagv_i,
    input  cache_pkg::tagv_t                          way1_tagv_i,
    input  cache_pkg::line_t                          way0_line_i,
    input  cache_pkg::line_t                          way1_line_i,
    output logic [1:0]                                way_we_o,
    output cache_pkg::wsel_t [`DCACHE_LINE_WORDS-1:0] way_wsel_o,
    output cache_pkg::tagv_t                          way_tagv_o,
    output cache_pkg::line_t                          way_line_o,
    output logic                                      stall_o,
    output logic                                      data_ok_o,
    output cache_pkg::word_t                          rdata_o,
    output mem_pkg::mem_req_t                         mem_req_o,
    input  mem_pkg::mem_rsp_t                         mem_rsp_i
);

    localparam int SETS = 1 << `DCACHE_INDEX_W;
    localparam int BYTES = `DCACHE_WORD_W / 8;
    localparam int BYTE_OFF_W = $clog2(BYTES);
    localparam int WORD_SEL_W = $clog2(`DCACHE_LINE_WORDS);

    // write bytes into one word of a line
    function automatic cache_pkg::line_t merge_word(
        input cache_pkg::line_t line,
        input logic [WORD_SEL_W-1:0] sel,
        input cache_pkg::wsel_t wsel,
        input cache_pkg::word_t wdata
    );
        cache_pkg::line_t merged;
        merged = line;
        for (int b = 0; b < BYTES; b++) begin
            if (wsel[b]) begin
                merged[sel][8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return merged;
    endfunction

    cache_pkg::index_t idx;
    cache_pkg::tag_t tag;
    logic [WORD_SEL_W-1:0] word_sel;
    logic active;
    logic hit0, hit1, hit, miss, hit_way;
    cache_pkg::line_t hit_line;

    logic [SETS-1:0] lru_q;
    logic [SETS-1:0][1:0] dirty_q;
    logic victim_way, victim_dirty;
    cache_pkg::tagv_t victim_tagv;
    cache_pkg::line_t victim_line;

    cache_pkg::miss_state_e state_q, state_d;
    logic wb_phase, fill_phase, fill_done;
    cache_pkg::line_t fill_line;

    //////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////

    assign idx = stage_req_i.addr.fields.index;
    assign tag = stage_req_i.addr.fields.tag;
    assign word_sel = stage_req_i.addr.fields.offset[BYTE_OFF_W +: WORD_SEL_W];
    assign active = stage_req_i.rvalid || stage_req_i.wvalid;

    assign hit0 = way0_tagv_i.valid && (way0_tagv_i.tag == tag);
    assign hit1 = way1_tagv_i.valid && (way1_tagv_i.tag == tag);
    assign hit = active && (hit0 || hit1);
    assign miss = active && !(hit0 || hit1);
    assign hit_way = hit1;
    assign hit_line = hit_way ? way1_line_i : way0_line_i;

    // replacement candidate
    assign victim_way = lru_q[idx];
    assign victim_tagv = victim_way ? way1_tagv_i : way0_tagv_i;
    assign victim_line = victim_way ? way1_line_i : way0_line_i;
    assign victim_dirty = victim_tagv.valid && dirty_q[idx][victim_way];

    //////////////////////////////////////////////////
    // miss FSM
    //////////////////////////////////////////////////

    assign wb_phase = (state_q == cache_pkg::IDLE && miss && victim_dirty)
                   || state_q == cache_pkg::WRITEBACK;
    assign fill_phase = (state_q == cache_pkg::IDLE && miss && !victim_dirty)
                     || state_q == cache_pkg::FILL;
    assign fill_done = fill_phase && mem_rsp_i.rd_valid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            cache_pkg::IDLE: begin
                if (miss && victim_dirty) begin
                    state_d = mem_rsp_i.wr_done ? cache_pkg::FILL : cache_pkg::WRITEBACK;
                end else if (miss && !mem_rsp_i.rd_valid) begin
                    state_d = cache_pkg::FILL;
                end
            end
            cache_pkg::WRITEBACK: begin
                if (mem_rsp_i.wr_done) begin
                    state_d = cache_pkg::FILL;
                end
            end
            cache_pkg::FILL: begin
                if (mem_rsp_i.rd_valid) begin
                    state_d = cache_pkg::IDLE;
                end
            end
            default: state_d = cache_pkg::IDLE;
        endcase
    end

    // state, LRU and dirty bits
    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= cache_pkg::IDLE;
            lru_q <= '0;
            dirty_q <= '0;
        end else begin
            state_q <= state_d;
            if (hit) begin
                lru_q[idx] <= !hit_way;
                if (stage_req_i.wvalid) begin
                    dirty_q[idx][hit_way] <= 1'b1;
                end
            end else if (fill_done) begin
                lru_q[idx] <= !victim_way;
                dirty_q[idx][victim_way] <= stage_req_i.wvalid;
            end
        end
    end

    //////////////////////////////////////////////////
    // array writes and outputs
    //////////////////////////////////////////////////

    // returned line with the pending store folded in
    assign fill_line = stage_req_i.wvalid
        ? merge_word(mem_rsp_i.rdata, word_sel, stage_req_i.wsel, stage_req_i.wdata)
        : mem_rsp_i.rdata;

    assign way_we_o[0] = (fill_done && !victim_way) || (hit && stage_req_i.wvalid && !hit_way);
    assign way_we_o[1] = (fill_done && victim_way) || (hit && stage_req_i.wvalid && hit_way);
    assign way_tagv_o = '{valid: 1'b1, tag: tag};

    // write hit replicates the word, the mask picks the lanes
    assign way_line_o = fill_done ? fill_line : {`DCACHE_LINE_WORDS{stage_req_i.wdata}};

    always_comb begin
        for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
            if (fill_done) begin
                way_wsel_o[w] = '1;
            end else if (w == int'(word_sel)) begin
                way_wsel_o[w] = stage_req_i.wsel;
            end else begin
                way_wsel_o[w] = '0;
            end
        end
    end

    assign stall_o = miss && !fill_done;
    assign data_ok_o = stage_req_i.rvalid && (hit || fill_done);
    assign rdata_o = hit ? hit_line[word_sel] : mem_rsp_i.rdata[word_sel];

    // line-aligned requests, victim line always on wdata
    always_comb begin
        mem_req_o.rd_req = fill_phase;
        mem_req_o.wr_req = wb_phase;
        mem_req_o.addr.fields.tag = wb_phase ? victim_tagv.tag : tag;
        mem_req_o.addr.fields.index = idx;
        mem_req_o.addr.fields.offset = '0;
        mem_req_o.wdata = victim_line;
    end

endmodule

`default_nettype wire

/* source/dcache_top.sv */
`default_nettype none

`include "dcache_settings.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::cpu_req_t   cpu_req_i,
    output logic                  stall_o,
    output logic                  data_ok_o,
    output cache_pkg::word_t      rdata_o,
    output mem_pkg::mem_req_t     mem_req_o,
    input  mem_pkg::mem_rsp_t     mem_rsp_i
);

    cache_pkg::cpu_req_t stage_req;
    cache_pkg::index_t read_index;

    cache_pkg::tagv_t way0_tagv;
    cache_pkg::tagv_t way1_tagv;
    cache_pkg::line_t way0_line;
    cache_pkg::line_t way1_line;

    logic [1:0] way_we;
    cache_pkg::wsel_t [`DCACHE_LINE_WORDS-1:0] way_wsel;
    cache_pkg::tagv_t way_tagv;
    cache_pkg::line_t way_line;

    dcache_request_stage u_stage (
        .clk          (clk),
        .rst          (rst),
        .cpu_req_i    (cpu_req_i),
        .stall_i      (stall_o),
        .stage_req_o  (stage_req),
        .read_index_o (read_index)
    );

    // both ways are written at the stage 2 index
    dcache_way_store u_way0 (
        .clk           (clk),
        .rst           (rst),
        .read_index_i  (read_index),
        .write_en_i    (way_we[0]),
        .write_index_i (stage_req.addr.fields.index),
        .write_wsel_i  (way_wsel),
        .write_tagv_i  (way_tagv),
        .write_line_i  (way_line),
        .tagv_o        (way0_tagv),
        .line_o        (way0_line)
    );

    dcache_way_store u_way1 (
        .clk           (clk),
        .rst           (rst),
        .read_index_i  (read_index),
        .write_en_i    (way_we[1]),
        .write_index_i (stage_req.addr.fields.index),
        .write_wsel_i  (way_wsel),
        .write_tagv_i  (way_tagv),
        .write_line_i  (way_line),
        .tagv_o        (way1_tagv),
        .line_o        (way1_line)
    );

    dcache_controller u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .stage_req_i (stage_req),
        .way0_tagv_i (way0_tagv),
        .way1_tagv_i (way1_tagv),
        .way0_line_i (way0_line),
        .way1_line_i (way1_line),
        .way_we_o    (way_we),
        .way_wsel_o  (way_wsel),
        .way_tagv_o  (way_tagv),
        .way_line_o  (way_line),
        .stall_o     (stall_o),
        .data_ok_o   (data_ok_o),
        .rdata_o     (rdata_o),
        .mem_req_o   (mem_req_o),
        .mem_rsp_i   (mem_rsp_i)
    );

endmodule

`default_nettype wire

/* tb/clock_gen.sv */
`default_nettype none

module clock_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD_NS = 40;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // active low, released on a rising edge
    initial begin
        rst_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* tb/mem_responder.sv */
`default_nettype none

`include "dcache_settings.svh"

module mem_responder (
    input  logic              clk_i,
    input  logic              rst_i,
    input  mem_pkg::mem_req_t mem_req_i,
    output mem_pkg::mem_rsp_t mem_rsp_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int KEY_W = `DCACHE_ADDR_W - `DCACHE_OFFSET_W;

    cache_pkg::line_t lines [logic [KEY_W-1:0]];
    mem_pkg::mem_rsp_t rsp_q = '0;
    logic busy = 1'b0;
    int remaining = 0;

    // every word starts from its own byte address
    function automatic cache_pkg::line_t initial_line(input logic [KEY_W-1:0] key);
        cache_pkg::line_t line;
        cache_pkg::word_t byte_addr;
        for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
            byte_addr = {key, 2'(w), 2'b00};
            line[w] = (byte_addr * 32'h9E37_79B1) ^ 32'h6A09_E667;
        end
        return line;
    endfunction

    always @(posedge clk_i) begin
        logic [KEY_W-1:0] key;
        key = mem_req_i.addr.raw[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W];
        if (!rst_i) begin
            rsp_q <= '0;
            busy = 1'b0;
            remaining = 0;
        end else if (rsp_q.rd_valid || rsp_q.wr_done) begin
            // pulse ends, the old request drops on this edge
            rsp_q.rd_valid <= 1'b0;
            rsp_q.wr_done <= 1'b0;
        end else if (!busy) begin
            if (mem_req_i.rd_req || mem_req_i.wr_req) begin
                busy = 1'b1;
                remaining = $urandom_range(8, 1);
            end
        end else begin
            remaining--;
            if (remaining == 0) begin
                busy = 1'b0;
                if (mem_req_i.wr_req) begin
                    lines[key] = mem_req_i.wdata;
                    rsp_q.wr_done <= 1'b1;
                end else begin
                    rsp_q.rdata <= lines.exists(key) ? lines[key] : initial_line(key);
                    rsp_q.rd_valid <= 1'b1;
                end
            end
        end
    end

    assign mem_rsp_o = rsp_q;

endmodule

`default_nettype wire

/* tb/dcache_tb.sv */
`default_nettype none

`include "dcache_settings.svh"

module dcache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_REQUESTS = 3000;
    localparam int MEM_TIMEOUT = 40;
    localparam int RESET_TIMEOUT = 40;
    localparam int SETS = 1 << `DCACHE_INDEX_W;
    localparam logic [`DCACHE_TAG_W-1:0] TAG_POOL [3] = '{20'h00012, 20'h3A5C0, 20'hFFFFF};
    localparam logic [`DCACHE_INDEX_W-1:0] SET_POOL [4] = '{8'h00, 8'h01, 8'h80, 8'hFF};

    logic clk;
    logic rst;
    cache_pkg::cpu_req_t cpu_req;
    logic stall;
    logic data_ok;
    cache_pkg::word_t rdata;
    mem_pkg::mem_req_t mem_req;
    mem_pkg::mem_rsp_t mem_rsp;

    // reference model of flat memory plus cache state
    cache_pkg::word_t model_mem [logic [29:0]];
    logic [1:0] m_valid [SETS] = '{default: '0};
    logic [1:0] m_dirty [SETS] = '{default: '0};
    logic m_lru [SETS] = '{default: 1'b0};
    cache_pkg::tag_t m_tag [SETS][2];

    // expected behavior of the request in stage 2
    logic exp_hit;
    logic exp_wb;
    cache_pkg::addr_u exp_wb_addr;
    cache_pkg::addr_u exp_fill_addr;
    cache_pkg::line_t exp_wb_line;
    cache_pkg::word_t exp_rdata;

    clock_gen u_clk (
        .clk_o (clk),
        .rst_o (rst)
    );

    mem_responder u_mem (
        .clk_i     (clk),
        .rst_i     (rst),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

    dcache_top uut (
        .clk       (clk),
        .rst       (rst),
        .cpu_req_i (cpu_req),
        .stall_o   (stall),
        .data_ok_o (data_ok),
        .rdata_o   (rdata),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp)
    );

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            report_failure($sformatf("Mismatch at %0t: %s is %b, expected %b",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic compare_word(input string name, input cache_pkg::word_t actual,
                                input cache_pkg::word_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("Mismatch at %0t: %s is %h, expected %h",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic compare_line(input string name, input cache_pkg::line_t actual,
                                input cache_pkg::line_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("Mismatch at %0t: %s is %h, expected %h",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic compare_addr(input string name, input cache_pkg::addr_u actual,
                                input cache_pkg::addr_u expected);
        if (actual.raw !== expected.raw) begin
            report_failure($sformatf("Mismatch at %0t: %s is %h, expected %h",
                                     $time, name, actual.raw, expected.raw));
        end
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic cache_pkg::word_t initial_word(input cache_pkg::word_t byte_addr);
        return (byte_addr * 32'h9E37_79B1) ^ 32'h6A09_E667;
    endfunction

    function automatic cache_pkg::word_t read_model(input logic [29:0] waddr);
        if (model_mem.exists(waddr)) begin
            return model_mem[waddr];
        end
        return initial_word({waddr, 2'b00});
    endfunction

    // only the enabled bytes change
    function automatic void write_model(input logic [29:0] waddr, input cache_pkg::wsel_t wsel,
                                        input cache_pkg::word_t wdata);
        cache_pkg::word_t word;
        word = read_model(waddr);
        for (int b = 0; b < `DCACHE_WORD_W / 8; b++) begin
            if (wsel[b]) begin
                word[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        model_mem[waddr] = word;
    endfunction

    function automatic cache_pkg::line_t model_line(input cache_pkg::addr_u line_addr);
        cache_pkg::line_t line;
        for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
            line[w] = read_model({line_addr.raw[31:4], 2'(w)});
        end
        return line;
    endfunction

    task automatic predict_access(input cache_pkg::cpu_req_t req);
        cache_pkg::index_t idx;
        cache_pkg::tag_t tag;
        logic hit0;
        logic hit1;
        logic way;
        idx = req.addr.fields.index;
        tag = req.addr.fields.tag;
        hit0 = m_valid[idx][0] && (m_tag[idx][0] == tag);
        hit1 = m_valid[idx][1] && (m_tag[idx][1] == tag);
        exp_hit = hit0 || hit1;
        exp_wb = 1'b0;
        exp_fill_addr.raw = {tag, idx, {`DCACHE_OFFSET_W{1'b0}}};
        if (exp_hit) begin
            way = hit1;
            m_dirty[idx][way] = m_dirty[idx][way] || req.wvalid;
        end else begin
            // lru names the victim
            way = m_lru[idx];
            if (m_valid[idx][way] && m_dirty[idx][way]) begin
                exp_wb = 1'b1;
                exp_wb_addr.raw = {m_tag[idx][way], idx, {`DCACHE_OFFSET_W{1'b0}}};
                exp_wb_line = model_line(exp_wb_addr);
            end
            m_valid[idx][way] = 1'b1;
            m_tag[idx][way] = tag;
            m_dirty[idx][way] = req.wvalid;
        end
        m_lru[idx] = !way;
        if (req.wvalid) begin
            write_model(req.addr.raw[31:2], req.wsel, req.wdata);
        end
        exp_rdata = read_model(req.addr.raw[31:2]);
    endtask

    //////////////////////////////////////////////////
    // stimulus and response checks
    //////////////////////////////////////////////////

    function automatic cache_pkg::cpu_req_t random_request();
        cache_pkg::cpu_req_t req;
        req = '0;
        req.wvalid = 1'($urandom_range(1));
        req.rvalid = !req.wvalid;
        req.addr.fields.tag = TAG_POOL[2'($urandom_range(2))];
        req.addr.fields.index = SET_POOL[2'($urandom_range(3))];
        req.addr.fields.offset = {2'($urandom_range(3)), 2'b00};
        if (req.wvalid) begin
            req.wsel = 4'($urandom_range(15, 1));
            req.wdata = $urandom();
        end
        return req;
    endfunction

    task automatic request_unchanged(input mem_pkg::mem_req_t held);
        compare_bit("mem_req_o.rd_req", mem_req.rd_req, held.rd_req);
        compare_bit("mem_req_o.wr_req", mem_req.wr_req, held.wr_req);
        compare_addr("mem_req_o.addr", mem_req.addr, held.addr);
        compare_line("mem_req_o.wdata", mem_req.wdata, held.wdata);
    endtask

    // returns at the negedge of the response cycle
    task automatic wait_for_memory(input logic is_write, input mem_pkg::mem_req_t held);
        int cycles;
        logic done;
        cycles = 0;
        done = is_write ? mem_rsp.wr_done : mem_rsp.rd_valid;
        while (!done) begin
            compare_bit("stall_o", stall, 1'b1);
            compare_bit("data_ok_o", data_ok, 1'b0);
            request_unchanged(held);
            cycles++;
            if (cycles > MEM_TIMEOUT) begin
                report_failure($sformatf("Timeout at %0t: no memory response after %0d cycles",
                                         $time, cycles));
            end
            @(negedge clk);
            done = is_write ? mem_rsp.wr_done : mem_rsp.rd_valid;
        end
        request_unchanged(held);
    endtask

    task automatic expect_response(input cache_pkg::cpu_req_t req);
        mem_pkg::mem_req_t held;
        @(negedge clk);
        if (exp_hit) begin
            compare_bit("stall_o", stall, 1'b0);
            compare_bit("mem_req_o.rd_req", mem_req.rd_req, 1'b0);
            compare_bit("mem_req_o.wr_req", mem_req.wr_req, 1'b0);
        end else begin
            compare_bit("stall_o", stall, 1'b1);
            compare_bit("mem_req_o.wr_req", mem_req.wr_req, exp_wb);
            if (exp_wb) begin
                compare_bit("mem_req_o.rd_req", mem_req.rd_req, 1'b0);
                compare_addr("mem_req_o.addr", mem_req.addr, exp_wb_addr);
                compare_line("mem_req_o.wdata", mem_req.wdata, exp_wb_line);
                held = mem_req;
                wait_for_memory(1'b1, held);
                compare_bit("stall_o", stall, 1'b1);
                @(negedge clk);
                compare_bit("mem_req_o.wr_req", mem_req.wr_req, 1'b0);
            end
            compare_bit("mem_req_o.rd_req", mem_req.rd_req, 1'b1);
            compare_addr("mem_req_o.addr", mem_req.addr, exp_fill_addr);
            held = mem_req;
            wait_for_memory(1'b0, held);
            compare_bit("stall_o", stall, 1'b0);
        end
        compare_bit("data_ok_o", data_ok, req.rvalid);
        if (req.rvalid) begin
            compare_word("rdata_o", rdata, exp_rdata);
        end
    endtask

    task automatic expect_idle();
        compare_bit("stall_o", stall, 1'b0);
        compare_bit("data_ok_o", data_ok, 1'b0);
        compare_bit("mem_req_o.rd_req", mem_req.rd_req, 1'b0);
        compare_bit("mem_req_o.wr_req", mem_req.wr_req, 1'b0);
    endtask

    initial begin
        cache_pkg::cpu_req_t cur;
        cache_pkg::cpu_req_t nxt;
        int cycles;
        void'($urandom(3567));
        cpu_req = '0;
        cycles = 0;
        while (rst !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                report_failure("Reset was never released");
            end
        end
        repeat (3) begin
            @(negedge clk);
            expect_idle();
        end
        @(posedge clk);
        cur = random_request();
        cpu_req <= cur;
        // each request is accepted on the edge after the previous one completes
        for (int n = 0; n < NUM_REQUESTS; n++) begin
            @(posedge clk);
            predict_access(cur);
            if (n == NUM_REQUESTS - 1) begin
                nxt = '0;
            end else begin
                nxt = random_request();
            end
            cpu_req <= nxt;
            expect_response(cur);
            cur = nxt;
        end
        @(negedge clk);
        expect_idle();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
source/cache_pkg.sv
source/mem_pkg.sv
source/dcache_request_stage.sv
source/dcache_way_store.sv
source/dcache_controller.sv
source/dcache_top.sv
tb/clock_gen.sv
tb/mem_responder.sv
tb/dcache_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --timescale 1ns/100ps
TOP       := dcache_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_TEXT := Finished with no errors

SOURCES := $(wildcard include/*.svh source/*.sv tb/*.sv)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
